/* list.f */
iq_pkg.sv
iq_status_if.sv
iq_issue_if.sv
iq_free_finder.sv
iq_entry_array.sv
iq_oldest_picker.sv
iq_slot_steer.sv
int_issue_queue.sv
tb_int_issue_queue.sv

/* Bender.yml */
package:
  name: int_issue_queue

sources:
  - iq_pkg.sv
  - iq_status_if.sv
  - iq_issue_if.sv
  - iq_free_finder.sv
  - iq_entry_array.sv
  - iq_oldest_picker.sv
  - iq_slot_steer.sv
  - int_issue_queue.sv
  - target: test
    files:
      - tb_int_issue_queue.sv

/* tb_int_issue_queue.sv */
`timescale 1ns/10ps

module tb_int_issue_queue
   import iq_pkg::*;
();

   localparam int NUM_ENTRIES     = 8;
   localparam int NUM_WB          = 2;
   localparam int ROB_ID_W        = ROB_W + 1;
   localparam int ROB_IDS         = 2 ** ROB_ID_W;
   localparam int RESET_CYCLES    = 5;
   localparam int NUM_TESTS       = 6;
   localparam int TEST_BUDGET     = 330; // cycles allowed per test
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_TESTS * TEST_BUDGET + 15;
   localparam int WAIT_LIMIT      = 100;

   logic                         clk;
   logic                         reset_n;
   logic                         instr0_valid;
   logic                         instr1_valid;
   iq_instr_t                    instr0;
   iq_instr_t                    instr1;
   logic                         instr0_src1_busy;
   logic                         instr0_src2_busy;
   logic                         instr1_src1_busy;
   logic                         instr1_src2_busy;
   logic [1:0]                   credits;
   logic [NUM_WB-1:0]            wb_valid;
   logic [NUM_WB-1:0][PRF_W-1:0] wb_prd;
   logic                         flush_valid;
   logic [ROB_W:0]               flush_robid;
   logic                         mul_slot_busy;
   logic                         slot0_valid;
   iq_instr_t                    slot0_instr;
   logic                         slot1_valid;
   iq_instr_t                    slot1_instr;

   // queue model, indexed by rob id
   logic      m_valid [ROB_IDS];
   iq_instr_t m_instr [ROB_IDS];
   logic      m_busy1 [ROB_IDS];
   logic      m_busy2 [ROB_IDS];
   int        m_count;
   int        exp_credits;
   logic      s0_ok; // slot 0 payload is a queued, ready entry
   logic      s1_ok;

   int             errors;
   string          test_name;
   logic [31:0]    lfsr;
   logic [ROB_W:0] next_rob;

   int_issue_queue #(.NUM_ENTRIES(NUM_ENTRIES), .NUM_WB(NUM_WB)) UUT (
      .clk              (clk),
      .reset_n          (reset_n),
      .instr0_valid     (instr0_valid),
      .instr1_valid     (instr1_valid),
      .instr0           (instr0),
      .instr1           (instr1),
      .instr0_src1_busy (instr0_src1_busy),
      .instr0_src2_busy (instr0_src2_busy),
      .instr1_src1_busy (instr1_src1_busy),
      .instr1_src2_busy (instr1_src2_busy),
      .credits          (credits),
      .wb_valid         (wb_valid),
      .wb_prd           (wb_prd),
      .flush_valid      (flush_valid),
      .flush_robid      (flush_robid),
      .mul_slot_busy    (mul_slot_busy),
      .slot0_valid      (slot0_valid),
      .slot0_instr      (slot0_instr),
      .slot1_valid      (slot1_valid),
      .slot1_instr      (slot1_instr)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
   endfunction

   // one lfsr step per tag bit
   function automatic logic [PRF_W-1:0] rand_tag();
      logic [PRF_W-1:0] t;
      for (int i = 0; i < PRF_W; i++) begin
         lfsr = lfsr_step(lfsr);
         t[i] = lfsr[0];
      end
      return t;
   endfunction

   function automatic iq_instr_t make_instr(input op_t op, input logic [ROB_W:0] rob,
                                            input logic [PRF_W-1:0] s1);
      iq_instr_t ins;
      ins.opcode    = op;
      ins.rs1_valid = 1'b1;
      ins.rs2_valid = 1'b1;
      ins.src1      = s1;
      ins.src2      = rand_tag();
      ins.dest      = rand_tag();
      ins.robid     = rob;
      return ins;
   endfunction

   // wrap bit flips the index order
   function automatic logic is_younger(input logic [ROB_W:0] rob, input logic [ROB_W:0] fl);
      return (rob[ROB_W] != fl[ROB_W]) != (rob[ROB_W-1:0] > fl[ROB_W-1:0]);
   endfunction

   function automatic logic entry_ready(input iq_instr_t ins);
      return m_valid[ins.robid] && m_instr[ins.robid] == ins &&
             !(ins.rs1_valid && m_busy1[ins.robid]) && !(ins.rs2_valid && m_busy2[ins.robid]);
   endfunction

   function automatic void model_add(input iq_instr_t ins, input logic b1, input logic b2);
      m_valid[ins.robid] = 1'b1;
      m_instr[ins.robid] = ins;
      m_busy1[ins.robid] = b1;
      m_busy2[ins.robid] = b2;
   endfunction

   always @(posedge clk) begin
      if (!reset_n) begin
         for (int r = 0; r < ROB_IDS; r++)
            m_valid[r] = 1'b0;
      end else begin
         if (slot0_valid)
            m_valid[slot0_instr.robid] = 1'b0;
         if (slot1_valid)
            m_valid[slot1_instr.robid] = 1'b0;
         if (flush_valid) begin
            for (int r = 0; r < ROB_IDS; r++) begin
               if (is_younger(ROB_ID_W'(r), flush_robid))
                  m_valid[r] = 1'b0;
            end
         end else begin
            if (instr0_valid)
               model_add(instr0, instr0_src1_busy, instr0_src2_busy);
            if (instr1_valid)
               model_add(instr1, instr1_src1_busy, instr1_src2_busy);
         end
         // wakeup also reaches same-cycle arrivals
         for (int r = 0; r < ROB_IDS; r++) begin
            for (int w = 0; w < NUM_WB; w++) begin
               if (wb_valid[w] && m_instr[r].src1 == wb_prd[w])
                  m_busy1[r] = 1'b0;
               if (wb_valid[w] && m_instr[r].src2 == wb_prd[w])
                  m_busy2[r] = 1'b0;
            end
         end
      end
      m_count = 0;
      for (int r = 0; r < ROB_IDS; r++)
         m_count += int'(m_valid[r]);
   end

   always_comb begin
      exp_credits = (NUM_ENTRIES - m_count) > 2 ? 2 : NUM_ENTRIES - m_count;
      s0_ok       = entry_ready(slot0_instr);
      s1_ok       = entry_ready(slot1_instr);
   end

   a_credits: assert property (@(posedge clk) disable iff (!reset_n) credits == exp_credits)
      else begin
         errors++;
         $display("FAIL %s credits expected %0d actual %0d", test_name,
                  $sampled(exp_credits), $sampled(credits));
      end

   a_slot0_known: assert property (@(posedge clk) disable iff (!reset_n) slot0_valid |-> s0_ok)
      else begin
         errors++;
         $display("%s: slot 0 issued an entry that was not queued and ready", test_name);
      end

   a_slot1_known: assert property (@(posedge clk) disable iff (!reset_n) slot1_valid |-> s1_ok)
      else begin
         errors++;
         $display("%s: slot 1 issued an entry that was not queued and ready", test_name);
      end

   a_slot0_op: assert property (@(posedge clk) disable iff (!reset_n)
                                slot0_valid |-> slot0_instr.opcode != op_bju)
      else begin
         errors++;
         $display("%s: a branch was steered onto slot 0", test_name);
      end

   a_slot1_op: assert property (@(posedge clk) disable iff (!reset_n)
                                slot1_valid |-> slot1_instr.opcode != op_mul)
      else begin
         errors++;
         $display("%s: a multiply was steered onto slot 1", test_name);
      end

   a_mul_hold: assert property (@(posedge clk) disable iff (!reset_n)
                                slot0_valid && mul_slot_busy |-> slot0_instr.opcode != op_mul)
      else begin
         errors++;
         $display("%s: a multiply issued while the multiplier was busy", test_name);
      end

   a_flush_quiet: assert property (@(posedge clk) disable iff (!reset_n)
                                   flush_valid |-> !slot0_valid && !slot1_valid)
      else begin
         errors++;
         $display("%s: a slot was valid during a flush", test_name);
      end

   a_distinct: assert property (@(posedge clk) disable iff (!reset_n)
                                slot0_valid && slot1_valid |->
                                slot0_instr.robid != slot1_instr.robid)
      else begin
         errors++;
         $display("%s: both slots issued the same entry", test_name);
      end

   task automatic expect_eq(input string what, input int expected, input int actual);
      assert (expected == actual) else begin
         errors++;
         $display("FAIL %s %s expected %0h actual %0h", test_name, what, expected, actual);
      end
   endtask

   task automatic dispatch(input op_t op0, input logic busy0, input op_t op1,
                           input logic busy1, input logic pair, input logic [PRF_W-1:0] tag,
                           output iq_instr_t sent0, output iq_instr_t sent1);
      int waited;
      int need;
      waited = 0;
      need   = pair ? 2 : 1;
      @(negedge clk);
      while (credits < need && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (waited == WAIT_LIMIT) begin
         errors++;
         $display("%s: dispatcher got no credits for %0d cycles", test_name, WAIT_LIMIT);
      end
      sent0 = make_instr(op0, next_rob, busy0 ? tag : rand_tag());
      next_rob++;
      sent1            = '0;
      instr0           = sent0;
      instr0_valid     = 1'b1;
      instr0_src1_busy = busy0;
      if (pair) begin
         sent1 = make_instr(op1, next_rob, busy1 ? tag : rand_tag());
         next_rob++;
         instr1           = sent1;
         instr1_valid     = 1'b1;
         instr1_src1_busy = busy1;
      end
      @(negedge clk);
      instr0_valid = 1'b0;
      instr1_valid = 1'b0;
   endtask

   task automatic writeback(input int port, input logic [PRF_W-1:0] tag);
      @(negedge clk);
      wb_valid[port] = 1'b1;
      wb_prd[port]   = tag;
      @(negedge clk);
      wb_valid = '0;
   endtask

   task automatic hold_quiet(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         assert (!(slot0_valid || slot1_valid)) else begin
            errors++;
            $display("%s: a slot went valid while its entries were still waiting", test_name);
         end
      end
   endtask

   task automatic wait_issue(output logic v0, output iq_instr_t s0,
                             output logic v1, output iq_instr_t s1);
      int waited;
      waited = 0;
      #1; // slot outputs settle after this edge's drives
      while (!(slot0_valid || slot1_valid) && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (!(slot0_valid || slot1_valid)) begin
         errors++;
         $display("%s: nothing issued within %0d cycles", test_name, WAIT_LIMIT);
      end
      v0 = slot0_valid;
      s0 = slot0_instr;
      v1 = slot1_valid;
      s1 = slot1_instr;
      @(negedge clk); // issue happens at the rising edge in between
   endtask

   task automatic wait_empty();
      int waited;
      waited = 0;
      while (m_count != 0 && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (m_count != 0) begin
         errors++;
         $display("%s: queue did not drain, %0d entries left", test_name, m_count);
      end
   endtask

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
      $display("Errors found");
      $finish;
   end

   initial begin
      iq_instr_t      a;
      iq_instr_t      b;
      iq_instr_t      s0;
      iq_instr_t      s1;
      logic           v0;
      logic           v1;
      logic [ROB_W:0] rob_seq [4];
      int             got;

      errors           = 0;
      test_name        = "reset";
      lfsr             = 32'ha3ec_788f;
      next_rob         = '0;
      reset_n          = 1'b0;
      instr0_valid     = 1'b0;
      instr1_valid     = 1'b0;
      instr0           = '0;
      instr1           = '0;
      instr0_src1_busy = 1'b0;
      instr0_src2_busy = 1'b0;
      instr1_src1_busy = 1'b0;
      instr1_src2_busy = 1'b0;
      wb_valid         = '0;
      wb_prd           = '0;
      flush_valid      = 1'b0;
      flush_robid      = '0;
      mul_slot_busy    = 1'b0;
      repeat (RESET_CYCLES) @(negedge clk);
      reset_n = 1'b1;

      // fill every entry with waiting instructions
      test_name = "credits";
      @(negedge clk);
      expect_eq("credits after reset", 2, credits);
      expect_eq("slot valids after reset", 0, {slot0_valid, slot1_valid});
      repeat (4) dispatch(op_alu, 1'b1, op_alu, 1'b1, 1'b1, 6'h3f, a, b);
      @(negedge clk);
      expect_eq("credits when full", 0, credits);
      hold_quiet(5);
      writeback(0, 6'h3f);
      wait_empty();

      test_name = "wakeup";
      dispatch(op_alu, 1'b1, op_alu, 1'b0, 1'b0, 6'h2a, a, b);
      hold_quiet(6);
      writeback(1, 6'h2a);
      wait_issue(v0, s0, v1, s1);
      expect_eq("slot0 valid", 1, v0);
      expect_eq("slot0 payload", a, s0);
      wait_empty();

      test_name = "oldest first";
      for (int i = 0; i < 4; i++) begin
         dispatch(op_alu, 1'b1, op_alu, 1'b0, 1'b0, 6'h15, a, b);
         rob_seq[i] = a.robid;
      end
      writeback(0, 6'h15);
      wait_issue(v0, s0, v1, s1);
      expect_eq("first pair valids", 3, {v0, v1});
      expect_eq("slot0 robid", rob_seq[0], s0.robid);
      expect_eq("slot1 robid", rob_seq[1], s1.robid);
      wait_issue(v0, s0, v1, s1);
      expect_eq("second pair valids", 3, {v0, v1});
      expect_eq("slot0 robid", rob_seq[2], s0.robid);
      expect_eq("slot1 robid", rob_seq[3], s1.robid);
      wait_empty();

      test_name = "steering";
      dispatch(op_mul, 1'b1, op_bju, 1'b1, 1'b1, 6'h21, a, b);
      writeback(0, 6'h21);
      wait_issue(v0, s0, v1, s1);
      expect_eq("mul and branch valids", 3, {v0, v1});
      expect_eq("slot0 robid", a.robid, s0.robid);
      expect_eq("slot1 robid", b.robid, s1.robid);
      wait_empty();
      dispatch(op_bju, 1'b1, op_bju, 1'b1, 1'b1, 6'h22, a, b);
      writeback(1, 6'h22);
      wait_issue(v0, s0, v1, s1);
      expect_eq("older branch valids", 1, {v0, v1});
      expect_eq("slot1 robid", a.robid, s1.robid);
      wait_issue(v0, s0, v1, s1);
      expect_eq("younger branch valids", 1, {v0, v1});
      expect_eq("slot1 robid", b.robid, s1.robid);
      wait_empty();

      test_name = "mul busy";
      mul_slot_busy = 1'b1;
      dispatch(op_mul, 1'b0, op_alu, 1'b0, 1'b1, 6'h00, a, b);
      wait_issue(v0, s0, v1, s1);
      expect_eq("alu past stalled mul valids", 1, {v0, v1});
      expect_eq("slot1 robid", b.robid, s1.robid);
      hold_quiet(10);
      expect_eq("entries while mul stalled", 1, m_count);
      mul_slot_busy = 1'b0;
      wait_issue(v0, s0, v1, s1);
      expect_eq("released mul valids", 2, {v0, v1});
      expect_eq("slot0 robid", a.robid, s0.robid);
      wait_empty();

      // rob ids 60 to 3 wrap around to 0, flush point 2 drops only 3
      test_name = "flush";
      next_rob  = 6'd60;
      repeat (4) dispatch(op_alu, 1'b1, op_alu, 1'b1, 1'b1, 6'h0c, a, b);
      writeback(0, 6'h0c);
      flush_valid = 1'b1;
      flush_robid = 6'd2;
      @(negedge clk);
      got         = credits;
      flush_valid = 1'b0;
      expect_eq("credits after flush", 1, got);
      wait_empty();
      expect_eq("credits when drained", 2, credits);

      $display("checks failed: %0d", errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

/* int_issue_queue.sv */
`timescale 1ns/10ps

module int_issue_queue
   import iq_pkg::*;
#(
   parameter int NUM_ENTRIES = 8,
   parameter int NUM_WB      = 2
) (
   input  logic                         clk,
   input  logic                         reset_n,
   input  logic                         instr0_valid,
   input  logic                         instr1_valid,
   input  iq_instr_t                    instr0,
   input  iq_instr_t                    instr1,
   input  logic                         instr0_src1_busy,
   input  logic                         instr0_src2_busy,
   input  logic                         instr1_src1_busy,
   input  logic                         instr1_src2_busy,
   output logic [1:0]                   credits,
   input  logic [NUM_WB-1:0]            wb_valid,
   input  logic [NUM_WB-1:0][PRF_W-1:0] wb_prd,
   input  logic                         flush_valid,
   input  logic [ROB_W:0]               flush_robid,
   input  logic                         mul_slot_busy,
   output logic                         slot0_valid,
   output iq_instr_t                    slot0_instr,
   output logic                         slot1_valid,
   output iq_instr_t                    slot1_instr
);

   localparam int ID_W = $clog2(NUM_ENTRIES);

   logic [NUM_ENTRIES-1:0] entry_valid;
   logic [ID_W-1:0]        alloc0_id;
   logic [ID_W-1:0]        alloc1_id;
   logic                   old0_valid;
   logic [ID_W-1:0]        old0_id;
   logic                   old1_valid;
   logic [ID_W-1:0]        old1_id;

   iq_status_if #(.NUM_ENTRIES(NUM_ENTRIES)) status_bus ();
   iq_issue_if  #(.NUM_ENTRIES(NUM_ENTRIES)) issue_bus ();

   assign slot0_valid = issue_bus.slot0_valid;
   assign slot1_valid = issue_bus.slot1_valid;

   iq_free_finder #(.NUM_ENTRIES(NUM_ENTRIES)) u_free_finder (
      .entry_valid (entry_valid),
      .alloc0_id   (alloc0_id),
      .alloc1_id   (alloc1_id),
      .credits     (credits)
   );

   iq_entry_array #(.NUM_ENTRIES(NUM_ENTRIES), .NUM_WB(NUM_WB)) u_entry_array (
      .clk              (clk),
      .reset_n          (reset_n),
      .instr0_valid     (instr0_valid),
      .instr1_valid     (instr1_valid),
      .instr0           (instr0),
      .instr1           (instr1),
      .instr0_src1_busy (instr0_src1_busy),
      .instr0_src2_busy (instr0_src2_busy),
      .instr1_src1_busy (instr1_src1_busy),
      .instr1_src2_busy (instr1_src2_busy),
      .alloc0_id        (alloc0_id),
      .alloc1_id        (alloc1_id),
      .wb_valid         (wb_valid),
      .wb_prd           (wb_prd),
      .flush_valid      (flush_valid),
      .flush_robid      (flush_robid),
      .entry_valid      (entry_valid),
      .status           (status_bus.store),
      .issue            (issue_bus.store),
      .slot0_instr      (slot0_instr),
      .slot1_instr      (slot1_instr)
   );

   iq_oldest_picker #(.NUM_ENTRIES(NUM_ENTRIES)) u_oldest_picker (
      .status     (status_bus.select),
      .old0_valid (old0_valid),
      .old0_id    (old0_id),
      .old1_valid (old1_valid),
      .old1_id    (old1_id)
   );

   iq_slot_steer #(.NUM_ENTRIES(NUM_ENTRIES)) u_slot_steer (
      .status        (status_bus.select),
      .old0_valid    (old0_valid),
      .old0_id       (old0_id),
      .old1_valid    (old1_valid),
      .old1_id       (old1_id),
      .mul_slot_busy (mul_slot_busy),
      .flush_valid   (flush_valid),
      .issue         (issue_bus.steer)
   );

endmodule

/* iq_slot_steer.sv */
`timescale 1ns/10ps

module iq_slot_steer
   import iq_pkg::*;
#(
   parameter int NUM_ENTRIES = 8
) (
   iq_status_if.select                    status,
   input  logic                           old0_valid,
   input  logic [$clog2(NUM_ENTRIES)-1:0] old0_id,
   input  logic                           old1_valid,
   input  logic [$clog2(NUM_ENTRIES)-1:0] old1_id,
   input  logic                           mul_slot_busy,
   input  logic                           flush_valid,
   iq_issue_if.steer                      issue
);

   op_t  op0;
   op_t  op1;
   logic old0_ok; // candidate not held back by the multiplier
   logic old1_ok;

   assign op0     = status.opcode[old0_id];
   assign op1     = status.opcode[old1_id];
   assign old0_ok = old0_valid && !(op0 == op_mul && mul_slot_busy);
   assign old1_ok = old1_valid && !(op1 == op_mul && mul_slot_busy);

   // slot 0 runs mul or alu, slot 1 runs bju or alu
   always_comb begin
      issue.slot0_valid = 1'b0;
      issue.slot0_id    = old0_id;
      issue.slot1_valid = 1'b0;
      issue.slot1_id    = old1_id;
      if (!flush_valid) begin
         if (old0_ok) begin
            case (op0)
               op_mul: begin
                  issue.slot0_valid = 1'b1;
                  issue.slot1_valid = old1_ok && op1 != op_mul; // second mul waits
               end
               op_bju: begin
                  issue.slot1_valid = 1'b1;
                  issue.slot1_id    = old0_id;
                  issue.slot0_valid = old1_ok && op1 != op_bju;
                  issue.slot0_id    = old1_id;
               end
               default: begin
                  if (old1_ok && op1 == op_mul) begin // alu yields slot 0 to the mul
                     issue.slot0_id = old1_id;
                     issue.slot1_id = old0_id;
                  end
                  issue.slot0_valid = 1'b1;
                  issue.slot1_valid = old1_ok;
               end
            endcase
         end else if (old1_ok) begin
            // older one is a stalled mul
            issue.slot1_valid = 1'b1;
         end
      end
   end

endmodule

/* iq_oldest_picker.sv */
`timescale 1ns/10ps

module iq_oldest_picker #(
   parameter int NUM_ENTRIES = 8
) (
   iq_status_if.select                    status,
   output logic                           old0_valid,
   output logic [$clog2(NUM_ENTRIES)-1:0] old0_id,
   output logic                           old1_valid,
   output logic [$clog2(NUM_ENTRIES)-1:0] old1_id
);

   localparam int ID_W  = $clog2(NUM_ENTRIES);
   localparam int AGE_W = ID_W + 1;

   logic [AGE_W-1:0] best0_age;
   logic [AGE_W-1:0] best1_age;

   // strict compare keeps the lower index on equal age
   always_comb begin
      old0_valid = 1'b0;
      old0_id    = '0;
      best0_age  = '0;
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         if (status.ready[i] && (!old0_valid || status.age[i] > best0_age)) begin
            old0_valid = 1'b1;
            old0_id    = ID_W'(i);
            best0_age  = status.age[i];
         end
      end
   end

   // runner-up, same scan with the winner masked out
   always_comb begin
      old1_valid = 1'b0;
      old1_id    = '0;
      best1_age  = '0;
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         if (status.ready[i] && !(old0_valid && old0_id == ID_W'(i)) &&
             (!old1_valid || status.age[i] > best1_age)) begin
            old1_valid = 1'b1;
            old1_id    = ID_W'(i);
            best1_age  = status.age[i];
         end
      end
   end

endmodule

/* iq_entry_array.sv */
`timescale 1ns/10ps

module iq_entry_array
   import iq_pkg::*;
#(
   parameter int NUM_ENTRIES = 8,
   parameter int NUM_WB      = 2
) (
   input  logic                              clk,
   input  logic                              reset_n,
   input  logic                              instr0_valid,
   input  logic                              instr1_valid,
   input  iq_instr_t                         instr0,
   input  iq_instr_t                         instr1,
   input  logic                              instr0_src1_busy,
   input  logic                              instr0_src2_busy,
   input  logic                              instr1_src1_busy,
   input  logic                              instr1_src2_busy,
   input  logic [$clog2(NUM_ENTRIES)-1:0]    alloc0_id,
   input  logic [$clog2(NUM_ENTRIES)-1:0]    alloc1_id,
   input  logic [NUM_WB-1:0]                 wb_valid,
   input  logic [NUM_WB-1:0][PRF_W-1:0]      wb_prd,
   input  logic                              flush_valid,
   input  logic [ROB_W:0]                    flush_robid,
   output logic [NUM_ENTRIES-1:0]            entry_valid,
   iq_status_if.store                        status,
   iq_issue_if.store                         issue,
   output iq_instr_t                         slot0_instr,
   output iq_instr_t                         slot1_instr
);

   localparam int ID_W  = $clog2(NUM_ENTRIES);
   localparam int AGE_W = ID_W + 1;

   iq_instr_t              entry_q [NUM_ENTRIES]; // payload
   logic [AGE_W-1:0]       age_q [NUM_ENTRIES];
   logic [NUM_ENTRIES-1:0] src1_busy;
   logic [NUM_ENTRIES-1:0] src2_busy;

   logic [NUM_ENTRIES-1:0] valid_next;
   logic [AGE_W-1:0]       age_next [NUM_ENTRIES];
   logic [NUM_ENTRIES-1:0] src1_busy_next;
   logic [NUM_ENTRIES-1:0] src2_busy_next;

   logic                   enq_a; // lower free entry gets written
   logic                   enq_b; // second free entry gets written
   iq_instr_t              instr_a;
   logic                   a_busy1;
   logic                   a_busy2;
   logic [1:0]             age_inc;

   // any writeback this cycle carrying the given tag
   function automatic logic wb_hit(input logic [PRF_W-1:0] tag);
      logic hit;
      hit = 1'b0;
      for (int w = 0; w < NUM_WB; w++) begin
         if (wb_valid[w] && wb_prd[w] == tag)
            hit = 1'b1;
      end
      return hit;
   endfunction

   function automatic logic [AGE_W-1:0] sat_add(input logic [AGE_W-1:0] a,
                                                input logic [1:0] inc);
      logic [AGE_W:0] sum;
      sum = a + inc;
      return sum[AGE_W] ? '1 : sum[AGE_W-1:0];
   endfunction

   // no enqueue while flushing
   assign enq_a   = !flush_valid && (instr0_valid || instr1_valid);
   assign enq_b   = !flush_valid && instr0_valid && instr1_valid;
   assign instr_a = instr0_valid ? instr0 : instr1;
   assign a_busy1 = instr0_valid ? instr0_src1_busy : instr1_src1_busy;
   assign a_busy2 = instr0_valid ? instr0_src2_busy : instr1_src2_busy;
   assign age_inc = enq_b ? 2'd2 : {1'b0, enq_a};

   always_comb begin
      valid_next = entry_valid;
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         // squash anything younger than the flush point
         if (flush_valid && ((entry_q[i].robid[ROB_W] ^ flush_robid[ROB_W]) ^
                             (entry_q[i].robid[ROB_W-1:0] > flush_robid[ROB_W-1:0])))
            valid_next[i] = 1'b0;
         age_next[i]       = sat_add(age_q[i], age_inc);
         src1_busy_next[i] = src1_busy[i] && !wb_hit(entry_q[i].src1);
         src2_busy_next[i] = src2_busy[i] && !wb_hit(entry_q[i].src2);
      end

      if (issue.slot0_valid) begin
         valid_next[issue.slot0_id] = 1'b0;
         age_next[issue.slot0_id]   = '0;
      end
      if (issue.slot1_valid) begin
         valid_next[issue.slot1_id] = 1'b0;
         age_next[issue.slot1_id]   = '0;
      end

      // new arrivals also see same-cycle writebacks
      if (enq_a) begin
         valid_next[alloc0_id]     = 1'b1;
         age_next[alloc0_id]       = AGE_W'(enq_b); // older of a pair gets 1
         src1_busy_next[alloc0_id] = a_busy1 && !wb_hit(instr_a.src1);
         src2_busy_next[alloc0_id] = a_busy2 && !wb_hit(instr_a.src2);
      end
      if (enq_b) begin
         valid_next[alloc1_id]     = 1'b1;
         age_next[alloc1_id]       = '0;
         src1_busy_next[alloc1_id] = instr1_src1_busy && !wb_hit(instr1.src1);
         src2_busy_next[alloc1_id] = instr1_src2_busy && !wb_hit(instr1.src2);
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         entry_valid <= '0;
         src1_busy   <= '0;
         src2_busy   <= '0;
         for (int i = 0; i < NUM_ENTRIES; i++)
            age_q[i] <= '0;
      end else begin
         entry_valid <= valid_next;
         src1_busy   <= src1_busy_next;
         src2_busy   <= src2_busy_next;
         for (int i = 0; i < NUM_ENTRIES; i++)
            age_q[i] <= age_next[i];
      end
   end

   always_ff @(posedge clk) begin
      if (enq_a)
         entry_q[alloc0_id] <= instr_a;
      if (enq_b)
         entry_q[alloc1_id] <= instr1;
   end

   always_comb begin
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         status.ready[i]  = entry_valid[i] &&
                            (!entry_q[i].rs1_valid || !src1_busy[i]) &&
                            (!entry_q[i].rs2_valid || !src2_busy[i]);
         status.age[i]    = age_q[i];
         status.opcode[i] = entry_q[i].opcode;
      end
   end

   assign slot0_instr = entry_q[issue.slot0_id];
   assign slot1_instr = entry_q[issue.slot1_id];

endmodule

/* iq_free_finder.sv */
`timescale 1ns/10ps

module iq_free_finder #(
   parameter int NUM_ENTRIES = 8
) (
   input  logic [NUM_ENTRIES-1:0]         entry_valid,
   output logic [$clog2(NUM_ENTRIES)-1:0] alloc0_id,
   output logic [$clog2(NUM_ENTRIES)-1:0] alloc1_id,
   output logic [1:0]                     credits
);

   localparam int ID_W = $clog2(NUM_ENTRIES);

   logic found0;
   logic found1;

   // lowest two free slots, scanning up from entry 0
   always_comb begin
      found0    = 1'b0;
      found1    = 1'b0;
      alloc0_id = '0;
      alloc1_id = '0;
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         if (!entry_valid[i]) begin
            if (!found0) begin
               found0    = 1'b1;
               alloc0_id = ID_W'(i);
            end else if (!found1) begin
               found1    = 1'b1;
               alloc1_id = ID_W'(i);
            end
         end
      end
   end

   // free count capped at two
   assign credits = found1 ? 2'd2 : (found0 ? 2'd1 : 2'd0);

endmodule

/* iq_issue_if.sv */
`timescale 1ns/10ps

interface iq_issue_if #(
   parameter int NUM_ENTRIES = 8
) ();

   localparam int ID_W = $clog2(NUM_ENTRIES);

   logic            slot0_valid; // entry leaves at the next edge
   logic [ID_W-1:0] slot0_id;
   logic            slot1_valid;
   logic [ID_W-1:0] slot1_id;

   modport steer (output slot0_valid, output slot0_id, output slot1_valid, output slot1_id);
   modport store (input slot0_valid, input slot0_id, input slot1_valid, input slot1_id);

endinterface

/* iq_status_if.sv */
`timescale 1ns/10ps

interface iq_status_if
   import iq_pkg::*;
#(
   parameter int NUM_ENTRIES = 8
) ();

   localparam int ID_W  = $clog2(NUM_ENTRIES);
   localparam int AGE_W = ID_W + 1;

   logic [NUM_ENTRIES-1:0] ready;               // valid and all used sources available
   logic [AGE_W-1:0]       age [NUM_ENTRIES];   // larger is older
   op_t                    opcode [NUM_ENTRIES];

   modport store  (output ready, output age, output opcode);
   modport select (input ready, input age, input opcode);

endinterface

/* iq_pkg.sv */
package iq_pkg;

   // physical register tag width
   localparam int PRF_W = 6;

   // rob index width, the full rob id carries one extra wrap bit on top
   localparam int ROB_W = 5;

   // execution class of an instruction
   typedef enum logic [1:0] {
      op_alu = 2'd0,
      op_bju = 2'd1, // branch or jump
      op_mul = 2'd2
   } op_t;

   // renamed instruction as handed over by dispatch
   typedef struct packed {
      op_t              opcode;
      logic             rs1_valid; // src1 is actually read
      logic             rs2_valid;
      logic [PRF_W-1:0] src1;
      logic [PRF_W-1:0] src2;
      logic [PRF_W-1:0] dest;
      logic [ROB_W:0]   robid;     // msb is the wrap bit
   } iq_instr_t;

endpackage
